/* design/nvram_pkg.sv */
// Backup RAM geometry and sector transfer widths
// Address, offset, sector index, data byte and LBA types

`default_nettype none

package nvram_pkg;

	// ==================================================
	// Geometry
	// ==================================================
	// 32 KiB image, 512 byte sectors, 64 sectors
	localparam int NVRAM_AW    = 15;
	localparam int SECTOR_AW   = 9;
	localparam int SECTOR_IW   = NVRAM_AW - SECTOR_AW;
	localparam int LAST_SECTOR = (1 << SECTOR_IW) - 1;

	// ==================================================
	// Types
	// ==================================================
	typedef logic [NVRAM_AW-1:0]  nvram_addr_t;
	typedef logic [SECTOR_AW-1:0] sector_off_t;
	typedef logic [SECTOR_IW-1:0] sector_idx_t;
	typedef logic [7:0]           byte_t;

	// Only the low SECTOR_IW bits are ever nonzero
	typedef logic [31:0]          sd_lba_t;

endpackage

`default_nettype wire

/* design/backup_ctrl_pkg.sv */
// Transfer sequencing types
// State encoding and transfer direction

`default_nettype none

package backup_ctrl_pkg;

	// Sector exchange states
	typedef enum logic [1:0] {
		IDLE,
		REQUEST,	// strobe up, waiting for sd_ack to rise
		ACKED,		// host moving data, waiting for sd_ack to fall
		NEXT		// step to next sector or finish
	} xfer_state_t;

	// Save moves RAM to card, load moves card to RAM
	typedef enum logic {
		DIR_SAVE,
		DIR_LOAD
	} xfer_dir_t;

endpackage

`default_nettype wire

/* design/request_tracker.sv */
// Backup request tracking
// Backup-enable latch, dirty flag for console writes,
// load/save command edges and autosave on menu open

`timescale 1ns/1ns
`default_nettype none

module request_tracker (
	input  logic                       clk_sys,
	input  logic                       reset,
	input  logic                       load_cmd,
	input  logic                       save_cmd,
	input  logic                       autosave_on,
	input  logic                       osd_open,
	input  logic                       img_mounted,
	input  logic                       img_readonly,
	input  logic                       console_we,
	input  logic                       busy,
	output logic                       start,
	output backup_ctrl_pkg::xfer_dir_t dir,
	output logic                       pending
);
	import backup_ctrl_pkg::*;

	logic backup_en;
	logic load_lvl;
	logic save_lvl;
	logic load_q;
	logic save_q;
	logic load_edge;
	logic save_edge;

	// Commands only count with a writable image mounted
	assign load_lvl  = load_cmd & backup_en;
	assign save_lvl  = (save_cmd | (osd_open & pending & autosave_on)) & backup_en;
	assign load_edge = load_lvl & ~load_q;
	assign save_edge = save_lvl & ~save_q;

	// Each new mount decides whether backup is allowed
	always_ff @(posedge clk_sys) begin
		if (reset)
			backup_en <= 1'b0;
		else if (img_mounted)
			backup_en <= ~img_readonly;
	end

	// Console wrote the RAM while the menu was closed
	always_ff @(posedge clk_sys) begin
		if (reset)
			pending <= 1'b0;
		else if (busy)
			pending <= 1'b0;
		else if (console_we && backup_en && !osd_open)
			pending <= 1'b1;
	end

	// Edges arriving during a transfer are dropped
	// A start pulse already issued counts as a transfer in progress
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			load_q <= 1'b0;
			save_q <= 1'b0;
			start  <= 1'b0;
			dir    <= DIR_SAVE;
		end else begin
			load_q <= load_lvl;
			save_q <= save_lvl;
			start  <= (load_edge | save_edge) & ~busy & ~start;
			if ((load_edge | save_edge) && !busy && !start)
				dir <= load_edge ? DIR_LOAD : DIR_SAVE;
		end
	end

	// FSM must have gone idle before a new request
	a_no_start_busy: assert property (@(posedge clk_sys) disable iff (reset)
		start |-> !busy);

endmodule

`default_nettype wire

/* design/sector_counter.sv */
// Sector index for the backup transfer
// Clears at transfer start, steps after each sector,
// flags the final sector of the image

`timescale 1ns/1ns
`default_nettype none

module sector_counter (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic                   clear,
	input  logic                   step,
	output nvram_pkg::sector_idx_t index,
	output logic                   last
);
	import nvram_pkg::*;

	// ==================================================
	// Index register
	// ==================================================
	always_ff @(posedge clk_sys) begin
		if (reset)
			index <= '0;
		else if (clear)
			index <= '0;
		else if (step)
			index <= index + 1'b1;
	end

	assign last = (index == sector_idx_t'(LAST_SECTOR));

	// FSM finishes instead of stepping past the end
	a_no_step_at_last: assert property (@(posedge clk_sys) disable iff (reset)
		step |-> !last);

endmodule

`default_nettype wire

/* design/transfer_fsm.sv */
// Sector transfer state machine
// Request strobes toward the host, sd_ack edge detection,
// per-sector counter control, busy and loading levels

`timescale 1ns/1ns
`default_nettype none

module transfer_fsm (
	input  logic                       clk_sys,
	input  logic                       reset,
	input  logic                       start,
	input  backup_ctrl_pkg::xfer_dir_t dir,
	input  logic                       sd_ack,
	input  logic                       last,
	output logic                       sd_rd,
	output logic                       sd_wr,
	output logic                       busy,
	output logic                       loading,
	output logic                       clear,
	output logic                       step
);
	import nvram_pkg::*;
	import backup_ctrl_pkg::*;

	xfer_state_t state;
	xfer_dir_t   dir_q;
	logic        ack_q;
	logic        ack_rise;
	logic        ack_fall;
	// Sectors stepped over in this transfer
	sector_idx_t step_cnt;

	assign ack_rise = sd_ack & ~ack_q;
	assign ack_fall = ~sd_ack & ack_q;

	// Counter control, seen by the counter on the same edge as the strobe
	assign clear   = (state == IDLE) & start;
	assign step    = (state == NEXT) & ~last;
	assign busy    = (state != IDLE);
	assign loading = busy & (dir_q == DIR_LOAD);

	always_ff @(posedge clk_sys) begin
		if (reset)
			ack_q <= 1'b0;
		else
			ack_q <= sd_ack;
	end

	// ==================================================
	// Sequencer
	// ==================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state    <= IDLE;
			dir_q    <= DIR_SAVE;
			sd_rd    <= 1'b0;
			sd_wr    <= 1'b0;
			step_cnt <= '0;
		end else begin
			case (state)
				IDLE: if (start) begin
					dir_q    <= dir;
					sd_rd    <= (dir == DIR_LOAD);
					sd_wr    <= (dir == DIR_SAVE);
					step_cnt <= '0;
					state    <= REQUEST;
				end
				// Host took the request, drop the strobe
				REQUEST: if (ack_rise) begin
					sd_rd <= 1'b0;
					sd_wr <= 1'b0;
					state <= ACKED;
				end
				ACKED: if (ack_fall)
					state <= NEXT;
				NEXT: if (last) begin
					state <= IDLE;
				end else begin
					sd_rd    <= (dir_q == DIR_LOAD);
					sd_wr    <= (dir_q == DIR_SAVE);
					step_cnt <= step_cnt + 1'b1;
					state    <= REQUEST;
				end
				default: state <= IDLE;
			endcase
		end
	end

	a_one_strobe: assert property (@(posedge clk_sys) disable iff (reset)
		!(sd_rd && sd_wr));

	// Counter reports the last sector only after the full image went by
	a_last_matches_tally: assert property (@(posedge clk_sys) disable iff (reset)
		(state == NEXT && last) |-> step_cnt == sector_idx_t'(LAST_SECTOR));

endmodule

`default_nettype wire

/* design/nvram_dpram.sv */
// Backup RAM, 32 KiB true dual port
// Port A serves the console, port B the host sector buffer
// Registered read data on both ports

`timescale 1ns/1ns
`default_nettype none

module nvram_dpram (
	input  logic                   clk_sys,
	input  nvram_pkg::nvram_addr_t a_addr,
	input  logic                   a_we,
	input  nvram_pkg::byte_t       a_wdata,
	output nvram_pkg::byte_t       a_rdata,
	input  nvram_pkg::nvram_addr_t b_addr,
	input  logic                   b_we,
	input  nvram_pkg::byte_t       b_wdata,
	output nvram_pkg::byte_t       b_rdata
);
	import nvram_pkg::*;

	byte_t mem [2**NVRAM_AW];

	// ==================================================
	// Port A, console side
	// ==================================================
	always_ff @(posedge clk_sys) begin
		if (a_we)
			mem[a_addr] <= a_wdata;
		a_rdata <= mem[a_addr];
	end

	// ==================================================
	// Port B, sector buffer side
	// ==================================================
	always_ff @(posedge clk_sys) begin
		if (b_we)
			mem[b_addr] <= b_wdata;
		b_rdata <= mem[b_addr];
	end

endmodule

`default_nettype wire

/* design/backup_top.sv */
// Backup RAM save/load engine, top level
// Request tracker, sector counter, transfer FSM and dual-port RAM
// Sector buffer addressing, LBA and activity light

`timescale 1ns/1ns
`default_nettype none

module backup_top (
	input  logic                   clk_sys,
	input  logic                   reset,
	// Console port
	input  nvram_pkg::nvram_addr_t nvram_addr,
	input  logic                   nvram_we,
	input  nvram_pkg::byte_t       nvram_wdata,
	output nvram_pkg::byte_t       nvram_rdata,
	// Menu
	input  logic                   load_cmd,
	input  logic                   save_cmd,
	input  logic                   autosave_on,
	input  logic                   osd_open,
	// Image status
	input  logic                   img_mounted,
	input  logic                   img_readonly,
	// Host sector interface
	output nvram_pkg::sd_lba_t     sd_lba,
	output logic                   sd_rd,
	output logic                   sd_wr,
	input  logic                   sd_ack,
	input  nvram_pkg::sector_off_t sd_buff_addr,
	input  logic                   sd_buff_wr,
	input  nvram_pkg::byte_t       sd_buff_dout,
	output nvram_pkg::byte_t       sd_buff_din,
	// Status
	output logic                   busy,
	output logic                   loading,
	output logic                   activity
);
	import nvram_pkg::*;
	import backup_ctrl_pkg::*;

	logic        start;
	xfer_dir_t   dir;
	logic        pending;
	logic        clear;
	logic        step;
	logic        last;
	sector_idx_t sector_index;
	nvram_addr_t b_addr;
	logic        b_we;

	// Sector number selects the 512 byte window of the image
	assign b_addr   = {sector_index, sd_buff_addr};
	assign sd_lba   = {{($bits(sd_lba_t) - SECTOR_IW){1'b0}}, sector_index};
	// Host writes land only inside an acknowledged exchange
	assign b_we     = sd_buff_wr & sd_ack;
	assign activity = busy | (autosave_on & pending);

	// ==================================================
	// Submodules
	// ==================================================
	request_tracker u_request_tracker (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.load_cmd     (load_cmd),
		.save_cmd     (save_cmd),
		.autosave_on  (autosave_on),
		.osd_open     (osd_open),
		.img_mounted  (img_mounted),
		.img_readonly (img_readonly),
		.console_we   (nvram_we),
		.busy         (busy),
		.start        (start),
		.dir          (dir),
		.pending      (pending)
	);

	sector_counter u_sector_counter (
		.clk_sys (clk_sys),
		.reset   (reset),
		.clear   (clear),
		.step    (step),
		.index   (sector_index),
		.last    (last)
	);

	transfer_fsm u_transfer_fsm (
		.clk_sys (clk_sys),
		.reset   (reset),
		.start   (start),
		.dir     (dir),
		.sd_ack  (sd_ack),
		.last    (last),
		.sd_rd   (sd_rd),
		.sd_wr   (sd_wr),
		.busy    (busy),
		.loading (loading),
		.clear   (clear),
		.step    (step)
	);

	nvram_dpram u_nvram_dpram (
		.clk_sys (clk_sys),
		.a_addr  (nvram_addr),
		.a_we    (nvram_we),
		.a_wdata (nvram_wdata),
		.a_rdata (nvram_rdata),
		.b_addr  (b_addr),
		.b_we    (b_we),
		.b_wdata (sd_buff_dout),
		.b_rdata (sd_buff_din)
	);

endmodule

`default_nettype wire

/* bench/backup_tb_tasks.svh */
// Testbench helpers
// Failure stop, value compare, console port write and read,
// expected card byte for a sector offset

`ifndef BACKUP_TB_TASKS_SVH
`define BACKUP_TB_TASKS_SVH

// Print the reason and the fail line, then end the run
task automatic stop_with_failure(input string why);
	$display("%s", why);
	$display("Simulation failed");
	$fatal(1, "backup_tb stopped on the first error");
endtask

task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
	if (actual !== expected) begin
		$display("** Error: %s expected 0x%0h actual 0x%0h", name, expected, actual);
		stop_with_failure("A checked value did not match");
	end
endtask

task automatic console_write(input nvram_addr_t addr, input byte_t data);
	@(posedge clk_sys);
	nvram_addr  <= addr;
	nvram_wdata <= data;
	nvram_we    <= 1'b1;
	@(posedge clk_sys);
	nvram_we    <= 1'b0;
endtask

// Registered read, data valid one cycle after the address
task automatic console_read(input nvram_addr_t addr, output byte_t data);
	@(posedge clk_sys);
	nvram_addr <= addr;
	@(posedge clk_sys);
	@(negedge clk_sys);
	data = nvram_rdata;
endtask

// Card content, mixes every bit of the image address
function automatic byte_t expected_byte(input sd_lba_t lba, input sector_off_t off);
	nvram_addr_t addr;
	byte_t       hi;
	addr = {lba[SECTOR_IW-1:0], off};
	hi   = byte_t'(addr[NVRAM_AW-1:8]) * 8'd37;
	return addr[7:0] ^ hi ^ 8'ha5;
endfunction

`endif

/* bench/backup_tb.sv */
// Testbench for the backup RAM save/load engine
// Clock and reset, DUT, host sector model,
// step table applied in a loop, checks and cycle timeout

`timescale 1ns/1ns
`default_nettype none

module backup_tb;
	import nvram_pkg::*;

	typedef enum int {ACT_MOUNT, ACT_WRITE, ACT_SAVE, ACT_LOAD, ACT_MENU, ACT_CHECK_RAM} action_t;

	// The arg field holds the readonly bit, write count or read stride
	typedef struct {
		string   name;
		action_t act;
		int      arg;
		int      exp_sectors;
		logic    exp_activity;
	} step_t;

	logic        clk_sys = 1'b0;
	logic        reset;
	nvram_addr_t nvram_addr;
	logic        nvram_we;
	byte_t       nvram_wdata;
	byte_t       nvram_rdata;
	logic        load_cmd, save_cmd, autosave_on, osd_open;
	logic        img_mounted, img_readonly;
	sd_lba_t     sd_lba;
	logic        sd_rd, sd_wr, sd_ack, sd_buff_wr;
	sector_off_t sd_buff_addr;
	byte_t       sd_buff_dout, sd_buff_din;
	logic        busy, loading, activity;

	step_t steps[$];
	byte_t ram_model [2**NVRAM_AW];
	byte_t card_image [2**NVRAM_AW];
	byte_t pattern [16];
	int    load_sectors, save_sectors, host_seq, cycle_count, cycle_limit;

	`include "backup_tb_tasks.svh"

	backup_top u_backup_top (
		.clk_sys (clk_sys), .reset (reset),
		.nvram_addr (nvram_addr), .nvram_we (nvram_we),
		.nvram_wdata (nvram_wdata), .nvram_rdata (nvram_rdata),
		.load_cmd (load_cmd), .save_cmd (save_cmd),
		.autosave_on (autosave_on), .osd_open (osd_open),
		.img_mounted (img_mounted), .img_readonly (img_readonly),
		.sd_lba (sd_lba), .sd_rd (sd_rd), .sd_wr (sd_wr), .sd_ack (sd_ack),
		.sd_buff_addr (sd_buff_addr), .sd_buff_wr (sd_buff_wr),
		.sd_buff_dout (sd_buff_dout), .sd_buff_din (sd_buff_din),
		.busy (busy), .loading (loading), .activity (activity)
	);

	always #2 clk_sys = ~clk_sys;

	always @(posedge clk_sys) begin
		cycle_count <= cycle_count + 1;
		if (cycle_limit > 0 && cycle_count > cycle_limit)
			stop_with_failure($sformatf("Timeout, no finish within %0d cycles", cycle_limit));
	end

	// ==================================================
	// Host sector model
	// ==================================================
	initial begin : host_model
		sd_lba_t lba;
		logic    is_load;
		int      wait_cycles;
		forever begin
			@(posedge clk_sys);
			if (!reset && (sd_rd || sd_wr)) begin
				lba     = sd_lba;
				is_load = sd_rd;
				check_value("host lba order", host_seq, lba);
				host_seq++;
				wait_cycles = 1 + int'($urandom % 4);
				repeat (wait_cycles) @(posedge clk_sys);
				sd_ack <= 1'b1;
				if (is_load) begin
					for (int i = 0; i < 512; i++) begin
						@(posedge clk_sys);
						sd_buff_addr <= sector_off_t'(i);
						sd_buff_dout <= expected_byte(lba, sector_off_t'(i));
						sd_buff_wr   <= 1'b1;
						ram_model[{lba[SECTOR_IW-1:0], sector_off_t'(i)}] =
							expected_byte(lba, sector_off_t'(i));
					end
					load_sectors++;
				end else begin
					// Read data trails the address by two edges here
					for (int i = 0; i < 514; i++) begin
						@(posedge clk_sys);
						if (i >= 2)
							card_image[{lba[SECTOR_IW-1:0], sector_off_t'(i - 2)}] = sd_buff_din;
						if (i < 512)
							sd_buff_addr <= sector_off_t'(i);
					end
					save_sectors++;
				end
				@(posedge clk_sys);
				sd_buff_wr <= 1'b0;
				sd_ack     <= 1'b0;
			end
		end
	end

	task automatic add_step(input string name, input action_t act, input int arg,
			input int exp_sectors, input logic exp_activity);
		step_t s;
		s.name         = name;
		s.act          = act;
		s.arg          = arg;
		s.exp_sectors  = exp_sectors;
		s.exp_activity = exp_activity;
		steps.push_back(s);
	endtask

	// Busy follows the command within a few cycles and falls after sector 63
	// The activity light stays on for the whole transfer
	task automatic wait_transfer(input string name, input logic is_load);
		@(negedge clk_sys);
		while (!busy)
			@(negedge clk_sys);
		while (busy) begin
			check_value({name, " loading"}, 32'(is_load), 32'(loading));
			check_value({name, " activity"}, 32'd1, 32'(activity));
			@(negedge clk_sys);
		end
	endtask

	task automatic run_step(input int r);
		step_t       s;
		int          load_before;
		int          save_before;
		nvram_addr_t addr;
		byte_t       data;
		s           = steps[r];
		load_before = load_sectors;
		save_before = save_sectors;
		host_seq    = 0;
		case (s.act)
			ACT_MOUNT: begin
				@(posedge clk_sys);
				img_readonly <= s.arg[0];
				img_mounted  <= 1'b1;
				@(posedge clk_sys);
				img_mounted  <= 1'b0;
			end
			ACT_WRITE:
				for (int j = 0; j < s.arg; j++) begin
					addr = nvram_addr_t'(j * 2053 + r * 131);
					data = pattern[j % 16] ^ byte_t'(r);
					console_write(addr, data);
					ram_model[addr] = data;
				end
			ACT_CHECK_RAM:
				for (int a = 0; a < 2**NVRAM_AW; a += s.arg) begin
					console_read(nvram_addr_t'(a), data);
					check_value($sformatf("%s at %h", s.name, a), 32'(ram_model[a]), 32'(data));
				end
			default: begin
				@(posedge clk_sys);
				save_cmd <= (s.act == ACT_SAVE);
				load_cmd <= (s.act == ACT_LOAD);
				osd_open <= (s.act == ACT_MENU);
				if (s.exp_sectors > 0)
					wait_transfer(s.name, s.act == ACT_LOAD);
				else
					repeat (20) @(posedge clk_sys);
				@(posedge clk_sys);
				save_cmd <= 1'b0;
				load_cmd <= 1'b0;
				osd_open <= 1'b0;
			end
		endcase
		@(negedge clk_sys);
		check_value({s.name, " load sectors"}, (s.act == ACT_LOAD) ? s.exp_sectors : 0,
			load_sectors - load_before);
		check_value({s.name, " save sectors"}, (s.act == ACT_LOAD) ? 0 : s.exp_sectors,
			save_sectors - save_before);
		check_value({s.name, " busy"}, 0, 32'(busy));
		check_value({s.name, " loading"}, 0, 32'(loading));
		check_value({s.name, " activity"}, 32'(s.exp_activity), 32'(activity));
		if (s.act == ACT_MENU)
			check_value({s.name, " pending"}, 0, 32'(u_backup_top.pending));
		if (s.act != ACT_LOAD && s.exp_sectors > 0)
			for (int a = 0; a < 2**NVRAM_AW; a++)
				check_value($sformatf("%s card byte %h", s.name, a), 32'(ram_model[a]),
					32'(card_image[a]));
	endtask

	// ==================================================
	// Stimulus
	// ==================================================
	initial begin
		void'($urandom(32'h6d5f));
		reset = 1'b1;
		{nvram_addr, nvram_we, nvram_wdata} = '0;
		{load_cmd, save_cmd, osd_open, img_mounted, img_readonly} = '0;
		autosave_on = 1'b1;
		{sd_ack, sd_buff_wr, sd_buff_addr, sd_buff_dout} = '0;
		for (int k = 0; k < 16; k++)
			pattern[k] = byte_t'($urandom);

		add_step("save before mount",   ACT_SAVE,      0,  0, 1'b0);
		add_step("write before mount",  ACT_WRITE,     4,  0, 1'b0);
		add_step("mount writable",      ACT_MOUNT,     0,  0, 1'b0);
		add_step("load image",          ACT_LOAD,      0, 64, 1'b0);
		add_step("read after load",     ACT_CHECK_RAM, 97, 0, 1'b0);
		add_step("write dirty bytes",   ACT_WRITE,    16,  0, 1'b1);
		add_step("save image",          ACT_SAVE,      0, 64, 1'b0);
		add_step("write again",         ACT_WRITE,     8,  0, 1'b1);
		add_step("menu autosave",       ACT_MENU,      0, 64, 1'b0);
		add_step("read after autosave", ACT_CHECK_RAM, 61, 0, 1'b0);
		add_step("mount read-only",     ACT_MOUNT,     1,  0, 1'b0);
		add_step("write read-only",     ACT_WRITE,     4,  0, 1'b0);
		add_step("save read-only",      ACT_SAVE,      0,  0, 1'b0);
		add_step("load read-only",      ACT_LOAD,      0,  0, 1'b0);
		// Worst case per row is a full image of host exchanges
		cycle_limit = steps.size() * 64 * 540 + 20000;

		repeat (5) @(posedge clk_sys);
		reset <= 1'b0;
		for (int r = 0; r < steps.size(); r++)
			run_step(r);
		$display("Simulation passed");
		$finish;
	end

endmodule

`default_nettype wire

/* project.f */
+incdir+bench
design/nvram_pkg.sv
design/backup_ctrl_pkg.sv
design/request_tracker.sv
design/sector_counter.sv
design/transfer_fsm.sv
design/nvram_dpram.sv
design/backup_top.sv
bench/backup_tb.sv

/* Makefile */
# Verilator build and run of the backup RAM engine testbench

OBJ_DIR = obj_dir
LOG     = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f project.f \
		--top-module backup_tb --Mdir $(OBJ_DIR) -o Vbackup_tb

# The pass line in the log decides the result
run: compile
	./$(OBJ_DIR)/Vbackup_tb | tee $(LOG)
	grep -q "^Simulation passed$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
